// File: ntm_tanh_top.f
rtl/ntm_tanh_pkg.sv
rtl/ntm_scalar_tanh_if.sv
rtl/ntm_fixed_divider.sv
rtl/ntm_scalar_tanh.sv
rtl/ntm_vector_tanh.sv
rtl/ntm_tanh_top.sv
testbench/ntm_tanh_tb.sv

// File: rtl/ntm_fixed_divider.sv
/*
 * Iterative signed divider
 * 32-step restoring division on magnitudes, sign applied at the end
 * Q16.16 over Q8.8 yields a Q8.8 quotient truncated toward zero
 */
module ntm_fixed_divider (
  input  logic                CLK,
  input  logic                RST,
  input  logic                div_start,
  input  ntm_tanh_pkg::wide_t dividend,
  input  ntm_tanh_pkg::wide_t divisor,
  output logic                div_done,
  output ntm_tanh_pkg::data_t quotient
);
  import ntm_tanh_pkg::*;

  localparam int W = $bits(wide_t);

  divider_state_t state;
  logic [$clog2(W)-1:0] step_q;

  // Datapath registers
  logic [W:0]   rem_q;
  logic [W-1:0] quo_q;
  logic [W-1:0] dsr_q;
  logic         neg_q;

  // One restoring step
  logic [W:0]   rem_shift;
  logic [W:0]   rem_sub;
  logic [W:0]   rem_next;
  logic [W-1:0] quo_next;
  logic [W-1:0] quo_signed;
  logic [W-1:0] dvd_mag;
  logic [W-1:0] dsr_mag;

  // Magnitudes, -2^31 maps to 2^31 unsigned
  assign dvd_mag = dividend[W-1] ? W'(-dividend) : W'(dividend);
  assign dsr_mag = divisor[W-1] ? W'(-divisor) : W'(divisor);

  // Bring next dividend bit into the partial remainder
  assign rem_shift = {rem_q[W-1:0], quo_q[W-1]};
  assign rem_sub   = rem_shift - {1'b0, dsr_q};

  // Sign bit of the trial subtraction decides restore
  assign rem_next = rem_sub[W] ? rem_shift : rem_sub;
  assign quo_next = {quo_q[W-2:0], ~rem_sub[W]};

  // Final sign on the completed quotient
  assign quo_signed = neg_q ? W'(-quo_next) : quo_next;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= div_idle;
      step_q   <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      case (state)
        div_idle: begin
          if (div_start) begin
            step_q <= '0;
            state  <= div_run;
          end
        end
        div_run: begin
          step_q <= step_q + 1'b1;
          // Last of 32 steps
          if (step_q == ($clog2(W))'(W - 1)) begin
            div_done <= 1'b1;
            state    <= div_idle;
          end
        end
        default: state <= div_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == div_idle && div_start) begin
      rem_q <= '0;
      quo_q <= dvd_mag;
      dsr_q <= dsr_mag;
      neg_q <= dividend[W-1] ^ divisor[W-1];
    end else if (state == div_run) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
      // Low half of the quotient is the Q8.8 result
      if (step_q == ($clog2(W))'(W - 1)) begin
        quotient <= quo_signed[$bits(data_t)-1:0];
      end
    end
  end

endmodule

// File: rtl/ntm_scalar_tanh.sv
/*
 * Scalar tanh unit
 * |x| >= 3.0 saturates to +-1.0 in one cycle, otherwise the
 * Pade form x(27 + x^2)/(27 + 9x^2) through the iterative divider
 */
module ntm_scalar_tanh (
  input logic CLK,
  input logic RST,
  ntm_scalar_tanh_if.slave scalar
);
  import ntm_tanh_pkg::*;

  scalar_state_t state;

  // Operand widened to Q16.16 arithmetic width
  wide_t op_wide;
  wide_t op_mag;
  logic  saturate;

  // x^2 back in Q8.8 scale
  wide_t x2_q;

  // Divider hookup
  logic  div_start;
  wide_t dividend;
  wide_t divisor;
  logic  div_done;
  data_t quotient;

  ////////////////////////////////////////////////////////////
  // Operand checks and Pade terms
  ////////////////////////////////////////////////////////////

  // Operand stays put until ready, so no local copy
  assign op_wide = wide_t'(scalar.operand);
  assign op_mag  = op_wide[31] ? -op_wide : op_wide;

  // Widened compare so -32768 has a proper magnitude
  assign saturate = (op_mag >= wide_t'(SAT_LIMIT_Q));

  // Numerator x*(27 + x^2), Q8.8 times Q8.8 gives Q16.16
  assign dividend = op_wide * (PADE_A_Q + x2_q);

  // Denominator 27 + 9x^2 stays Q8.8
  assign divisor  = PADE_A_Q + PADE_B * x2_q;

  // Terms are ready during form, divider latches them there
  assign div_start = (state == sc_form);

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= sc_idle;
      scalar.ready <= 1'b0;
    end else begin
      scalar.ready <= 1'b0;
      case (state)
        sc_idle: begin
          if (scalar.start) begin
            if (saturate) begin
              // Answer right away, stay idle
              scalar.ready <= 1'b1;
            end else begin
              state <= sc_square;
            end
          end
        end
        sc_square: begin
          state <= sc_form;
        end
        sc_form: begin
          state <= sc_divide;
        end
        sc_divide: begin
          // Quotient passes straight out with ready
          if (div_done) begin
            scalar.ready <= 1'b1;
            state        <= sc_idle;
          end
        end
        default: state <= sc_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      sc_idle: begin
        // Sign of the input picks +1 or -1
        if (scalar.start && saturate) begin
          scalar.result <= scalar.operand[15] ? -ONE_Q : ONE_Q;
        end
      end
      sc_square: begin
        // Arithmetic shift keeps x^2 in Q8.8
        x2_q <= (op_wide * op_wide) >>> FRAC_BITS;
      end
      sc_divide: begin
        if (div_done) begin
          scalar.result <= quotient;
        end
      end
      default: ;
    endcase
  end

  // Divider, busy only on the Pade path
  ntm_fixed_divider u_divider (
    .CLK       (CLK),
    .RST       (RST),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_done  (div_done),
    .quotient  (quotient)
  );

endmodule

// File: rtl/ntm_scalar_tanh_if.sv
/*
 * Scalar tanh request bus
 * Sequencer issues start with an operand, scalar unit answers
 * with one ready pulse carrying the result
 */
interface ntm_scalar_tanh_if;
  import ntm_tanh_pkg::*;

  // One-cycle request pulse
  logic  start;
  // Held from start until ready
  data_t operand;
  // One-cycle answer pulse
  logic  ready;
  // Valid only while ready is high
  data_t result;

  // Sequencer side
  modport master (
    output start,
    output operand,
    input  ready,
    input  result
  );

  // Scalar unit side
  modport slave (
    input  start,
    input  operand,
    output ready,
    output result
  );

endinterface

// File: rtl/ntm_tanh_pkg.sv
/*
 * Shared types and constants for the vector tanh engine
 * Q8.8 data, element counts, Q16.16 intermediates and FSM states
 */
package ntm_tanh_pkg;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Signed Q8.8 element
  typedef logic signed [15:0] data_t;

  // Vector length and element index
  typedef logic [15:0] count_t;

  // Signed Q16.16 products, numerator and denominator
  typedef logic signed [31:0] wide_t;

  ////////////////////////////////////////////////////////////
  // Fixed-point constants
  ////////////////////////////////////////////////////////////

  localparam int    FRAC_BITS   = 8;
  // 1.0, the saturated magnitude
  localparam data_t ONE_Q       = 16'sd256;
  // 3.0, at or above this tanh is taken as +-1
  localparam data_t SAT_LIMIT_Q = 16'sd768;
  // Pade constant 27.0
  localparam wide_t PADE_A_Q    = 32'sd6912;
  // Plain integer factor on x^2 in the denominator
  localparam int    PADE_B      = 9;

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {vec_idle, vec_wait_input, vec_wait_result} vector_state_t;

  typedef enum logic [1:0] {sc_idle, sc_square, sc_form, sc_divide} scalar_state_t;

  typedef enum logic {div_idle, div_run} divider_state_t;

endpackage

// File: rtl/ntm_tanh_top.sv
/*
 * Vector tanh engine top level
 * Sequencer and scalar tanh unit joined by the scalar request bus
 */
module ntm_tanh_top (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_tanh_pkg::count_t SIZE_IN,
  input  logic                 DATA_IN_ENABLE,
  input  ntm_tanh_pkg::data_t  DATA_IN,
  output logic                 DATA_OUT_ENABLE,
  output ntm_tanh_pkg::data_t  DATA_OUT,
  output logic                 READY
);

  ////////////////////////////////////////////////////////////
  // Internal bus
  ////////////////////////////////////////////////////////////

  // One element in flight between sequencer and scalar unit
  ntm_scalar_tanh_if scalar_bus ();

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  ntm_vector_tanh u_vector (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY),
    .scalar          (scalar_bus.master)
  );

  ////////////////////////////////////////////////////////////
  // Scalar tanh
  ////////////////////////////////////////////////////////////

  // Pade path plus saturation, divider inside
  ntm_scalar_tanh u_scalar (
    .CLK    (CLK),
    .RST    (RST),
    .scalar (scalar_bus.slave)
  );

endmodule

// File: rtl/ntm_vector_tanh.sv
/*
 * Vector tanh sequencer
 * Takes one element per input strobe, runs it through the scalar
 * unit and returns one result strobe per element, READY on the last
 */
module ntm_vector_tanh (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_tanh_pkg::count_t SIZE_IN,
  input  logic                 DATA_IN_ENABLE,
  input  ntm_tanh_pkg::data_t  DATA_IN,
  output logic                 DATA_OUT_ENABLE,
  output ntm_tanh_pkg::data_t  DATA_OUT,
  output logic                 READY,
  ntm_scalar_tanh_if.master    scalar
);
  import ntm_tanh_pkg::*;

  vector_state_t state;

  // Latched vector length, never zero
  count_t size_q;
  // Index of the element in flight
  count_t index_q;
  logic   last_elem;

  assign last_elem = (index_q == count_t'(size_q - 1'b1));

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= vec_idle;
      size_q          <= '0;
      index_q         <= '0;
      scalar.start    <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      READY           <= 1'b0;
    end else begin
      // Strobes default low
      scalar.start    <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      case (state)
        vec_idle: begin
          if (START) begin
            // Zero length runs as a single element
            size_q  <= (SIZE_IN == '0) ? count_t'(1) : SIZE_IN;
            index_q <= '0;
            state   <= vec_wait_input;
          end
        end
        vec_wait_input: begin
          // Every element gets its own scalar start
          if (DATA_IN_ENABLE) begin
            scalar.start <= 1'b1;
            state        <= vec_wait_result;
          end
        end
        vec_wait_result: begin
          // Input strobes here are dropped
          if (scalar.ready) begin
            DATA_OUT        <= scalar.result;
            DATA_OUT_ENABLE <= 1'b1;
            if (last_elem) begin
              // Done flag lines up with the last result
              READY <= 1'b1;
              state <= vec_idle;
            end else begin
              index_q <= index_q + 1'b1;
              state   <= vec_wait_input;
            end
          end
        end
        default: state <= vec_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand register
  ////////////////////////////////////////////////////////////

  // Held until the next capture, covers start through ready
  always_ff @(posedge CLK) begin
    if (state == vec_wait_input && DATA_IN_ENABLE) begin
      scalar.operand <= DATA_IN;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the vector tanh testbench with Verilator.
# Pass or fail comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ntm_tanh_sim

# Compile testbench and RTL into one executable
verilator --binary --timing --top-module ntm_tanh_tb -f ntm_tanh_top.f -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Run the simulation and keep its output
./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, pass line missing from $LOG"
  exit 1
fi

// File: testbench/ntm_tanh_tb.sv
/*
 * Vector tanh engine testbench
 * Drives vectors through the top level, predicts each result with
 * a Pade reference model and checks order, values and READY
 */
module ntm_tanh_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ntm_tanh_pkg::*;

  // 7 Pade, 6 saturated, lengths 1/5/16, 200 random, 6 with junk, 1 zero-size
  localparam int TOTAL_ELEMS  = 7 + 6 + (1 + 5 + 16) + 200 + 6 + 1;
  localparam longint WATCHDOG_NS = 40 * (TOTAL_ELEMS * 60 + 1000);
  // Generous bound on one element's latency, in cycles
  localparam int RESULT_LIMIT = 100;

  logic   CLK;
  logic   RST;
  logic   START;
  count_t SIZE_IN;
  logic   DATA_IN_ENABLE;
  data_t  DATA_IN;
  logic   DATA_OUT_ENABLE;
  data_t  DATA_OUT;
  logic   READY;

  // Expected results in input order
  data_t exp_data [$];
  bit    exp_last [$];
  data_t exp_input [$];
  // Elements of the vector being sent
  data_t stim_q [$];

  int seed = 32'h9a9e;
  int sent_count;
  int out_count;

  data_t exp_value;
  data_t exp_in;
  bit    exp_ready;

  data_t small_vals [7] = '{16'sd0, 16'sd128, -16'sd128, 16'sd256, -16'sd256,
                            16'sd742, -16'sd742};
  data_t sat_vals [6] = '{16'sd768, -16'sd768, 16'sd1920, -16'sd1920,
                          16'sh7fff, 16'sh8000};
  data_t junk_vals [6] = '{16'sd100, -16'sd900, 16'sd600, -16'sd50,
                           16'sd3000, 16'sd200};
  int lengths [3] = '{1, 5, 16};

  ntm_tanh_top dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////

  // tanh in Q8.8, saturate at |x| >= 3.0, else x(27 + x^2)/(27 + 9x^2)
  function automatic data_t ref_tanh(input data_t x);
    int xi;
    int mag;
    int x2;
    int num;
    int den;
    xi  = int'(x);
    mag = (xi < 0) ? -xi : xi;
    // 768 is 3.0
    if (mag >= 768) begin
      return (xi < 0) ? -16'sd256 : 16'sd256;
    end
    x2  = (xi * xi) >>> 8;
    // 6912 is 27.0 in Q8.8
    num = xi * (6912 + x2);
    den = 6912 + 9 * x2;
    // Integer division truncates toward zero
    return data_t'(num / den);
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////

  // Outputs change on the rising edge, sampled on the falling one
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) begin
        if (exp_data.size() == 0) begin
          $display("Result strobe at %0d ns with no element outstanding", $time);
          stop_on_error();
        end else begin
          exp_value = exp_data.pop_front();
          exp_ready = exp_last.pop_front();
          exp_in    = exp_input.pop_front();
          check_value(int'(DATA_OUT), int'(exp_value),
                      $sformatf("DATA_OUT for input %0d", exp_in));
          // READY only with the last result of a vector
          check_value(int'(READY), int'(exp_ready),
                      $sformatf("READY with result for input %0d", exp_in));
          out_count++;
        end
      end else if (READY) begin
        $display("READY pulsed at %0d ns without a result strobe", $time);
        stop_on_error();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Inputs change 5 ns after the rising edge
  task automatic next_drive_slot();
    @(posedge CLK);
    #5;
  endtask

  function automatic data_t random_element();
    int r;
    r = $random(seed);
    // Half full range (mostly saturated), half within +-4.0
    if (r[8]) begin
      return data_t'(r[31:16]);
    end
    return data_t'({{5{r[26]}}, r[26:16]});
  endfunction

  function automatic int random_gap(input int max_gap);
    int r;
    if (max_gap == 0) begin
      return 0;
    end
    r = $random(seed);
    return int'(r[7:0]) % (max_gap + 1);
  endfunction

  // Block until n results have been seen, bounded
  task automatic wait_for_outputs(input int n);
    int waited;
    waited = 0;
    while (out_count < n) begin
      @(posedge CLK);
      waited++;
      if (waited > RESULT_LIMIT) begin
        $display("No result strobe within %0d cycles for element %0d", RESULT_LIMIT, n);
        stop_on_error();
      end
    end
    #5;
  endtask

  task automatic send_element(input data_t x, input bit last, input bit junk);
    DATA_IN        = x;
    DATA_IN_ENABLE = 1'b1;
    exp_data.push_back(ref_tanh(x));
    exp_last.push_back(last);
    exp_input.push_back(x);
    sent_count++;
    next_drive_slot();
    DATA_IN_ENABLE = 1'b0;
    if (junk) begin
      // Element now pending, both strobes must be dropped
      DATA_IN        = ~x;
      DATA_IN_ENABLE = 1'b1;
      START          = 1'b1;
      SIZE_IN        = count_t'(1);
      next_drive_slot();
      DATA_IN_ENABLE = 1'b0;
      START          = 1'b0;
    end
    wait_for_outputs(sent_count);
  endtask

  // One whole vector from stim_q, READY expected with the last result
  task automatic run_vector(input count_t size_field, input bit junk, input int max_gap);
    int i;
    START   = 1'b1;
    SIZE_IN = size_field;
    next_drive_slot();
    START   = 1'b0;
    for (i = 0; i < stim_q.size(); i++) begin
      repeat (random_gap(max_gap)) next_drive_slot();
      send_element(stim_q[i], i == stim_q.size() - 1, junk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int r;
    int len;
    int remaining;
    int k;
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    sent_count     = 0;
    out_count      = 0;

    repeat (10) @(posedge CLK);
    #5;
    RST = 1'b0;
    // Outputs must come out of reset quiet
    check_value(int'(DATA_OUT), 0, "DATA_OUT after reset");
    check_value(int'(DATA_OUT_ENABLE), 0, "DATA_OUT_ENABLE after reset");
    check_value(int'(READY), 0, "READY after reset");
    next_drive_slot();

    // Pade path
    stim_q.delete();
    foreach (small_vals[k]) stim_q.push_back(small_vals[k]);
    run_vector(count_t'(7), 1'b0, 0);

    // Saturation, extremes included
    stim_q.delete();
    foreach (sat_vals[k]) stim_q.push_back(sat_vals[k]);
    run_vector(count_t'(6), 1'b0, 0);

    // Vector lengths
    for (k = 0; k < 3; k++) begin
      stim_q.delete();
      repeat (lengths[k]) stim_q.push_back(random_element());
      run_vector(count_t'(lengths[k]), 1'b0, 2);
    end

    // Random vectors with idle gaps
    remaining = 200;
    while (remaining > 0) begin
      r   = $random(seed);
      len = 1 + int'(r[4:0]);
      if (len > remaining) begin
        len = remaining;
      end
      stim_q.delete();
      repeat (len) stim_q.push_back(random_element());
      repeat (random_gap(7)) next_drive_slot();
      run_vector(count_t'(len), 1'b0, 7);
      remaining -= len;
    end

    // Stray DATA_IN_ENABLE and START while a result is pending
    stim_q.delete();
    foreach (junk_vals[k]) stim_q.push_back(junk_vals[k]);
    run_vector(count_t'(6), 1'b1, 3);

    // Zero length runs one element
    stim_q.delete();
    stim_q.push_back(16'sd384);
    run_vector(count_t'(0), 1'b0, 0);

    // Let any stray strobe show up
    repeat (20) next_drive_slot();
    $display("PASS: all tests");
    $finish;
  end

  // Watchdog against a hung DUT
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped producing results", WATCHDOG_NS);
    stop_on_error();
  end

endmodule
